//--- vlog.f
verilog/videoPkg.sv
verilog/rasterCounter.sv
verilog/boxObject.sv
verilog/backgroundGrid.sv
verilog/objectsMux.sv
verilog/videoTop.sv
tb/videoTopTb.sv

//--- tb/videoTopTb.sv
/*
 Directed testbench for the pixel pipeline on a 20 x 14 raster.
 A reference model of scan order, layers and color expansion predicts every output pixel.
*/
`timescale 1ns/100ps

module videoTopTb import videoPkg::*; ();

	localparam int hActive = 16;
	localparam int hTotal = 20;
	localparam int vActive = 12;
	localparam int vTotal = 14;
	localparam int gridStep = 4;
	localparam int boxWidth = 5;
	localparam int boxHeight = 3;
	localparam int frameLen = hTotal * vTotal;

	logic clk;
	logic resetN;
	pixelPosT boxOrigin;
	rgb332T fillColor;
	rgb332T borderColor;
	rgb332T gridColor;
	rgb332T backgroundColor;
	rgb24T pixelColor;
	pixelPosT pixelPos;
	logic videoActive;

	// model copies of the DUT frame latch
	pixelPosT latOrigin;
	pixelPosT prevPos;
	rgb332T latFill;
	rgb332T latBorder;
	rgb332T latGrid;
	rgb332T bgSeen;
	logic frameStart;
	int scanIndex;
	int seed;

	videoTop #(
		.hActive(hActive),
		.hTotal(hTotal),
		.vActive(vActive),
		.vTotal(vTotal),
		.gridStep(gridStep),
		.boxWidth(boxWidth),
		.boxHeight(boxHeight)
	) DUT (
		.clk(clk),
		.resetN(resetN),
		.boxOrigin(boxOrigin),
		.fillColor(fillColor),
		.borderColor(borderColor),
		.gridColor(gridColor),
		.backgroundColor(backgroundColor),
		.pixelColor(pixelColor),
		.pixelPos(pixelPos),
		.videoActive(videoActive)
	);

	always #2 clk = ~clk;

	function automatic pixelPosT makePos(input int x, input int y);
		pixelPosT p;
		p.x = coordT'(x);
		p.y = coordT'(y);
		return p;
	endfunction

	// channel bits on top with copies of the channel lsb below
	function automatic colorChanT widenChannel(input int bits, input int width);
		colorChanT chan;
		int b;
		chan = colorChanT'(bits << (8 - width));
		for (b = 0; b < 8 - width; b++) begin
			chan[b] = bits[0];
		end
		return chan;
	endfunction

	function automatic rgb24T expand332(input rgb332T c);
		rgb24T result;
		result.red = widenChannel(c[7:5], 3);
		result.green = widenChannel(c[4:2], 3);
		result.blue = widenChannel(c[1:0], 2);
		return result;
	endfunction

	// expected rgb332 for one position in priority order
	function automatic rgb332T modelColor(input pixelPosT p);
		int x;
		int y;
		int ox;
		int oy;
		x = p.x;
		y = p.y;
		ox = latOrigin.x;
		oy = latOrigin.y;
		if (x >= hActive || y >= vActive) begin
			return '0;
		end
		if (x >= ox && x < ox + boxWidth && y >= oy && y < oy + boxHeight) begin
			// outer ring is border
			if (x == ox || x == ox + boxWidth - 1 || y == oy || y == oy + boxHeight - 1) begin
				return latBorder;
			end
			return latFill;
		end
		if (x % gridStep == 0 || y % gridStep == 0 || x == hActive - 1 || y == vActive - 1) begin
			return latGrid;
		end
		return bgSeen;
	endfunction

	task automatic checkColor(input string name, input rgb24T expected, input rgb24T actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "pixel color mismatch");
		end
	endtask

	task automatic checkPos(input string name, input pixelPosT expected, input pixelPosT actual);
		if (actual !== expected) begin
			$display("** Error %s: expected (%0d,%0d), actual (%0d,%0d)", name,
				expected.x, expected.y, actual.x, actual.y);
			$display("ERRORS FOUND");
			$fatal(1, "pixel position mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "flag mismatch");
		end
	endtask

	// advance one clock and sample 1 ns after the edge
	task automatic step();
		// background feeds the mux unlatched and shows one clock later
		bgSeen = backgroundColor;
		@(posedge clk);
		#1;
		frameStart = (prevPos == makePos(hTotal - 1, vTotal - 1)) && (pixelPos == '0);
		if (frameStart) begin
			latOrigin = boxOrigin;
			latFill = fillColor;
			latBorder = borderColor;
			latGrid = gridColor;
		end
		prevPos = pixelPos;
	endtask

	task automatic waitFrameStart(input string name);
		int count;
		count = 0;
		do begin
			step();
			count++;
		end while (!frameStart && count < 3 * frameLen);
		if (!frameStart) begin
			$display("%s: no frame boundary arrived within three frames", name);
			$display("ERRORS FOUND");
			$fatal(1, "frame boundary timeout");
		end
		scanIndex = 0;
	endtask

	// check position, active flag and color of the next count outputs
	task automatic checkPixels(input string name, input int count);
		pixelPosT expPos;
		for (int i = 0; i < count; i++) begin
			expPos = makePos(scanIndex % hTotal, scanIndex / hTotal);
			checkPos(name, expPos, pixelPos);
			checkFlag(name, (expPos.x < hActive) && (expPos.y < vActive), videoActive);
			checkColor(name, expand332(modelColor(expPos)), pixelColor);
			step();
			scanIndex = (scanIndex + 1) % frameLen;
		end
	endtask

	// apply new settings at changePoint and check through the frame boundary
	task automatic changeMidFrame(input string name, input int changePoint, input pixelPosT origin,
			input rgb332T fill, input rgb332T border, input rgb332T grid, input rgb332T bg);
		checkPixels(name, changePoint);
		boxOrigin = origin;
		fillColor = fill;
		borderColor = border;
		gridColor = grid;
		backgroundColor = bg;
		checkPixels(name, frameLen - changePoint);
		checkFlag({name, " boundary"}, 1'b1, frameStart);
	endtask

	task automatic testReset();
		for (int i = 0; i < 4; i++) begin
			step();
			checkFlag("reset", 1'b0, videoActive);
			checkColor("reset", '0, pixelColor);
			checkPos("reset", '0, pixelPos);
		end
		resetN = 1'b1;
		step();
		// first output after release is an active (0,0) in black
		checkPos("reset release", '0, pixelPos);
		checkFlag("reset release", 1'b1, videoActive);
		checkColor("reset release", '0, pixelColor);
	endtask

	task automatic testRasterScan();
		waitFrameStart("raster scan");
		checkPixels("raster scan", frameLen);
		checkFlag("raster scan wrap", 1'b1, frameStart);
	endtask

	task automatic testGridAndBackground();
		changeMidFrame("grid and background", 60, '1, 8'he0, 8'hff, 8'h1c, 8'h03);
		checkPixels("grid and background", frameLen);
	endtask

	task automatic testBoxPriority();
		// over grid lines, then clipped at right and bottom, then at the corner
		changeMidFrame("box priority", 30, makePos(2, 3), 8'h92, 8'h6d, 8'h1c, 8'h03);
		checkPixels("box priority", frameLen);
		changeMidFrame("box clipped", 30, makePos(13, 10), 8'h92, 8'h6d, 8'h1c, 8'h03);
		checkPixels("box clipped", frameLen);
		changeMidFrame("box corner", 30, makePos(0, 0), 8'h49, 8'hf0, 8'h1c, 8'h03);
		checkPixels("box corner", frameLen);
	endtask

	task automatic testFrameLatch();
		changeMidFrame("frame latch late", 250, makePos(8, 4), 8'h49, 8'hb6, 8'he3, 8'h25);
		changeMidFrame("frame latch early", 10, makePos(4, 8), 8'h13, 8'hc8, 8'h7c, 8'h82);
		checkPixels("frame latch", frameLen);
	endtask

	task automatic testColorExpansion();
		repeat (20) begin
			changeMidFrame("color expansion", 10 + $urandom % 240,
				makePos($urandom % hTotal, $urandom % vTotal), rgb332T'($urandom),
				rgb332T'($urandom), rgb332T'($urandom), rgb332T'($urandom));
		end
		checkPixels("color expansion", frameLen);
	endtask

	initial begin
		seed = 32'h122f;
		void'($urandom(seed));
		clk = 1'b0;
		resetN = 1'b0;
		boxOrigin = '1;
		fillColor = '0;
		borderColor = '0;
		gridColor = '0;
		backgroundColor = '0;
		// reset values of the DUT frame latch
		latOrigin = '1;
		latFill = '0;
		latBorder = '0;
		latGrid = '0;
		bgSeen = '0;
		prevPos = '0;
		frameStart = 1'b0;
		scanIndex = 0;
		testReset();
		testRasterScan();
		testGridAndBackground();
		testBoxPriority();
		testFrameLatch();
		testColorExpansion();
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- verilog/videoTop.sv
/*
 Top of the pixel pipeline.
 Raster counter feeds the box and grid layers, the mux merges them into 24-bit color.
 Output for a position appears one clock after the counter shows it.
*/
`timescale 1ns/100ps

module videoTop import videoPkg::*; #(
	parameter int hActive = 640,
	parameter int hTotal = 800,
	parameter int vActive = 480,
	parameter int vTotal = 525,
	parameter int gridStep = 32,
	parameter int boxWidth = 32,
	parameter int boxHeight = 16
) (
	input logic clk,
	input logic resetN,
	input pixelPosT boxOrigin,
	input rgb332T fillColor,
	input rgb332T borderColor,
	input rgb332T gridColor,
	input rgb332T backgroundColor,
	output rgb24T pixelColor,
	output pixelPosT pixelPos,
	output logic videoActive
);

	// scan state shared by both layers
	pixelPosT position;
	logic active;
	logic newFrame;
	// layer outputs into the mux
	layerT boxLayer;
	layerT gridLayer;

	rasterCounter #(
		.hActive(hActive),
		.hTotal(hTotal),
		.vActive(vActive),
		.vTotal(vTotal)
	) rasterCounterInst (
		.clk(clk),
		.resetN(resetN),
		.position(position),
		.active(active),
		.newFrame(newFrame)
	);

	boxObject #(
		.boxWidth(boxWidth),
		.boxHeight(boxHeight)
	) boxObjectInst (
		.clk(clk),
		.resetN(resetN),
		.position(position),
		.newFrame(newFrame),
		.boxOrigin(boxOrigin),
		.fillColor(fillColor),
		.borderColor(borderColor),
		.layer(boxLayer)
	);

	backgroundGrid #(
		.hActive(hActive),
		.vActive(vActive),
		.gridStep(gridStep)
	) backgroundGridInst (
		.clk(clk),
		.resetN(resetN),
		.position(position),
		.newFrame(newFrame),
		.gridColor(gridColor),
		.layer(gridLayer)
	);

	objectsMux objectsMuxInst (
		.clk(clk),
		.resetN(resetN),
		.boxLayer(boxLayer),
		.gridLayer(gridLayer),
		.backgroundColor(backgroundColor),
		.position(position),
		.active(active),
		.pixelColor(pixelColor),
		.pixelPos(pixelPos),
		.videoActive(videoActive)
	);

endmodule

//--- verilog/objectsMux.sv
/*
 Combines the drawing layers over a background color.
 Priority is box, then grid, then background; blanking is forced to black.
 The chosen RGB332 color is registered with its position and widened to 24 bits.
*/
`timescale 1ns/100ps

module objectsMux import videoPkg::*; (
	input logic clk,
	input logic resetN,
	input layerT boxLayer,
	input layerT gridLayer,
	input rgb332T backgroundColor,
	input pixelPosT position,
	input logic active,
	output rgb24T pixelColor,
	output pixelPosT pixelPos,
	output logic videoActive
);

	rgb332T selColor;
	rgb332T colorReg;

	// fixed priority, box on top
	always_comb begin
		if (!active) begin
			selColor = '0;
		end else if (boxLayer.drawRequest) begin
			selColor = boxLayer.color;
		end else if (gridLayer.drawRequest) begin
			selColor = gridLayer.color;
		end else begin
			selColor = backgroundColor;
		end
	end

	// one pipeline stage, position travels with its color
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			colorReg <= '0;
			pixelPos <= '0;
			videoActive <= 1'b0;
		end else begin
			colorReg <= selColor;
			pixelPos <= position;
			videoActive <= active;
		end
	end

	// replicate each channel lsb to fill 8 bits
	assign pixelColor.red = {colorReg[7:5], {5{colorReg[5]}}};
	assign pixelColor.green = {colorReg[4:2], {5{colorReg[2]}}};
	assign pixelColor.blue = {colorReg[1:0], {6{colorReg[0]}}};

	// blanking is always black at the output
	assert property (@(posedge clk) disable iff (!resetN)
		!videoActive |-> (pixelColor == '0))
	else $error("color driven outside the active area");

endmodule

//--- verilog/backgroundGrid.sv
/*
 Background layer of grid lines plus a frame around the visible area.
 Lines fall on multiples of gridStep, the color is taken once per frame.
*/
`timescale 1ns/100ps

module backgroundGrid import videoPkg::*; #(
	parameter int hActive = 640,
	parameter int vActive = 480,
	parameter int gridStep = 32
) (
	input logic clk,
	input logic resetN,
	input pixelPosT position,
	input logic newFrame,
	input rgb332T gridColor,
	output layerT layer
);

	// low coordinate bits that must be zero on a grid line
	localparam int gridBits = $clog2(gridStep);
	localparam coordT xEdge = coordT'(hActive - 1);
	localparam coordT yEdge = coordT'(vActive - 1);

	// grid test by low bits needs a power of two
	if ((gridStep < 2) || ((gridStep & (gridStep - 1)) != 0)) begin : gridStepCheck
		$fatal(1, "gridStep must be a power of two, at least 2");
	end

	rgb332T gridReg;
	logic onGrid;
	logic onEdge;

	// frame latch
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			gridReg <= '0;
		end else if (newFrame) begin
			gridReg <= gridColor;
		end
	end

	always_comb begin
		onGrid = (position.x[gridBits-1:0] == '0) || (position.y[gridBits-1:0] == '0);
		// right and bottom screen edges
		onEdge = (position.x == xEdge) || (position.y == yEdge);
		layer.drawRequest = onGrid || onEdge;
		layer.color = gridReg;
	end

endmodule

//--- verilog/boxObject.sv
/*
 Rectangular object with a one pixel border.
 Origin and colors are taken once per frame on newFrame, so the box never tears.
 The layer output is combinational from the current scan position.
*/
`timescale 1ns/100ps

module boxObject import videoPkg::*; #(
	parameter int boxWidth = 32,
	parameter int boxHeight = 16
) (
	input logic clk,
	input logic resetN,
	input pixelPosT position,
	input logic newFrame,
	input pixelPosT boxOrigin,
	input rgb332T fillColor,
	input rgb332T borderColor,
	output layerT layer
);

	// one extra bit so the far edge cannot wrap
	typedef logic [coordWidth:0] wideCoordT;

	pixelPosT originReg;
	rgb332T fillReg;
	rgb332T borderReg;
	wideCoordT xEnd;
	wideCoordT yEnd;
	logic inX;
	logic inY;
	logic onBorder;

	// frame latch
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			// all ones is off screen, no box in the first frame
			originReg <= '1;
			fillReg <= '0;
			borderReg <= '0;
		end else if (newFrame) begin
			originReg <= boxOrigin;
			fillReg <= fillColor;
			borderReg <= borderColor;
		end
	end

	always_comb begin
		// last column and row covered by the box
		xEnd = {1'b0, originReg.x} + wideCoordT'(boxWidth - 1);
		yEnd = {1'b0, originReg.y} + wideCoordT'(boxHeight - 1);
		inX = (position.x >= originReg.x) && ({1'b0, position.x} <= xEnd);
		inY = (position.y >= originReg.y) && ({1'b0, position.y} <= yEnd);
		// outer ring of the rectangle
		onBorder = (position.x == originReg.x) || ({1'b0, position.x} == xEnd) ||
			(position.y == originReg.y) || ({1'b0, position.y} == yEnd);
		layer.drawRequest = inX && inY;
		if (onBorder) begin
			layer.color = borderReg;
		end else begin
			layer.color = fillReg;
		end
	end

	// origin only moves right after a frame boundary
	assert property (@(posedge clk) disable iff (!resetN)
		!$stable(originReg) |-> $past(newFrame))
	else $error("box origin changed inside a frame");

endmodule

//--- verilog/rasterCounter.sv
/*
 Raster scan counter, one pixel per clock.
 Walks x across each line and y down the frame, wrapping at the totals.
 active and newFrame are registered together with the position they describe.
*/
`timescale 1ns/100ps

module rasterCounter import videoPkg::*; #(
	parameter int hActive = 640,
	parameter int hTotal = 800,
	parameter int vActive = 480,
	parameter int vTotal = 525
) (
	input logic clk,
	input logic resetN,
	output pixelPosT position,
	output logic active,
	output logic newFrame
);

	// limits in coordinate width
	localparam coordT xLast = coordT'(hTotal - 1);
	localparam coordT yLast = coordT'(vTotal - 1);
	localparam coordT xActive = coordT'(hActive);
	localparam coordT yActive = coordT'(vActive);
	localparam coordT xTotal = coordT'(hTotal);
	localparam coordT yTotal = coordT'(vTotal);

	pixelPosT nextPos;

	// next scan position
	always_comb begin
		nextPos = position;
		if (position.x == xLast) begin
			nextPos.x = '0;
			// line wrap steps y
			if (position.y == yLast) begin
				nextPos.y = '0;
			end else begin
				nextPos.y = position.y + 1'b1;
			end
		end else begin
			nextPos.x = position.x + 1'b1;
		end
	end

	// flags decoded from the next position so they line up with it
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			position <= '0;
			// (0,0) lies inside the visible area
			active <= 1'b1;
			newFrame <= 1'b0;
		end else begin
			position <= nextPos;
			active <= (nextPos.x < xActive) && (nextPos.y < yActive);
			newFrame <= (nextPos.x == xLast) && (nextPos.y == yLast);
		end
	end

	// counters stay inside the raster
	assert property (@(posedge clk) disable iff (!resetN)
		(position.x < xTotal) && (position.y < yTotal))
	else $error("raster position left the frame");

endmodule

//--- verilog/videoPkg.sv
/*
 Shared types for the raster pixel pipeline.
 Holds the coordinate and color vectors and the position, layer and 24-bit color structs.
 Modules pull these in with a wildcard import in their header.
*/
package videoPkg;

	// 10 bits covers an 800 x 525 raster
	localparam int coordWidth = 10;

	// one screen coordinate, x or y
	typedef logic [coordWidth-1:0] coordT;

	// packed color: red [7:5], green [4:2], blue [1:0]
	typedef logic [7:0] rgb332T;

	// one channel of the expanded output color
	typedef logic [7:0] colorChanT;

	// scan position, x in the upper half
	typedef struct packed {
		coordT x;
		coordT y;
	} pixelPosT;

	// what a drawing layer hands to the mux
	typedef struct packed {
		logic drawRequest;
		rgb332T color;
	} layerT;

	// full output color
	typedef struct packed {
		colorChanT red;
		colorChanT green;
		colorChanT blue;
	} rgb24T;

endpackage
